// ==== files.f ====
src/qdr_pkg.sv
src/qdr_rd_if.sv
src/qdr_cmd_phaser.sv
src/qdr_rd_tracker.sv
src/qdr_rd_capture.sv
src/qdr_ctl_top.sv
test/qdr_ctl_checker.sv
test/qdr_scoreboard.sv
test/tb_qdr_ctl.sv

// ==== src/qdr_cmd_phaser.sv ====
`timescale 1ns/100ps

module qdr_cmd_phaser import qdr_pkg::*; (
	input  logic                                  clk_ctl,
	input  logic                                  serdes_rst,

	// User request side
	input  logic                                  rd_en,
	input  logic [ADDR_BITS-1:0]                  rd_addr,
	input  logic                                  wr_en,
	input  logic [ADDR_BITS-1:0]                  wr_addr,
	input  logic [CTRL_WIDTH-1:0]                 wr_data,

	// RAM lanes, one entry per phase of the controller cycle
	output logic [ADDR_SLOTS-1:0][ADDR_BITS-1:0]  qdr_a_lanes,
	output logic                                  qdr_wps_n,
	output logic                                  qdr_rps_n,
	output logic [BURST_BEATS-1:0]                qdr_bws_n_lanes,
	output logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_d_lanes,

	qdr_rd_if.phaser                              rd
);

	// Previous cycle write word and enable
	logic [CTRL_WIDTH-1:0] wr_data_ff;
	logic                  wr_en_ff;

	// Pick word k out of a user word
	function automatic logic [RAM_WIDTH-1:0] word_of(input logic [CTRL_WIDTH-1:0] data,
		input int k);
		return data[k*RAM_WIDTH +: RAM_WIDTH];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Payload lanes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_ctl) begin
		wr_data_ff <= wr_data;

		// Address bus alternates, write port first then read port
		qdr_a_lanes[0] <= wr_addr;
		qdr_a_lanes[1] <= rd_addr;

		// First half of the data lags one cycle behind the write command
		// Beats go out odd word first to match the write clock phasing
		qdr_d_lanes[0] <= word_of(wr_data_ff, 1);
		qdr_d_lanes[1] <= word_of(wr_data_ff, 0);

		// Second half comes from the current word
		qdr_d_lanes[2] <= word_of(wr_data, 3);
		qdr_d_lanes[3] <= word_of(wr_data, 2);
	end

	////////////////////////////////////////////////////////////////////////////
	// Selects and byte writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_ctl) begin
		if (serdes_rst) begin
			wr_en_ff        <= 1'b0;
			qdr_wps_n       <= 1'b1;
			qdr_rps_n       <= 1'b1;
			qdr_bws_n_lanes <= '1;
			rd.rd_issue     <= 1'b0;
		end else begin
			wr_en_ff  <= wr_en;
			qdr_wps_n <= !wr_en;
			qdr_rps_n <= !rd_en;

			// No byte masking, every lane enabled while its half burst is written
			// Upper slots follow this write, lower slots the one before
			qdr_bws_n_lanes <= {{(BURST_BEATS/2){!wr_en}}, {(BURST_BEATS/2){!wr_en_ff}}};

			// Tracker sees the read in the cycle rps_n drops
			rd.rd_issue <= rd_en;
		end
	end

endmodule

// ==== src/qdr_ctl_top.sv ====
`timescale 1ns/100ps

module qdr_ctl_top import qdr_pkg::*; (
	input  logic                                  clk_ctl,
	input  logic                                  serdes_rst,

	// User read port
	input  logic                                  rd_en,
	input  logic [ADDR_BITS-1:0]                  rd_addr,
	output logic                                  rd_valid,
	output logic [CTRL_WIDTH-1:0]                 rd_data,
	output logic                                  rd_err,
	output logic                                  rd_timeout,

	// User write port
	input  logic                                  wr_en,
	input  logic [ADDR_BITS-1:0]                  wr_addr,
	input  logic [CTRL_WIDTH-1:0]                 wr_data,

	// RAM side lanes toward the serializers
	output logic [ADDR_SLOTS-1:0][ADDR_BITS-1:0]  qdr_a_lanes,
	output logic                                  qdr_wps_n,
	output logic                                  qdr_rps_n,
	output logic [BURST_BEATS-1:0]                qdr_bws_n_lanes,
	output logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_d_lanes,

	// RAM side lanes from the deserializers
	input  logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_q_lanes,
	input  logic [BURST_BEATS-1:0]                qdr_qvld_lanes
);

	qdr_rd_if u_rd_if ();

	// Command and write data phasing
	qdr_cmd_phaser u_phaser (
		.clk_ctl         (clk_ctl),
		.serdes_rst      (serdes_rst),
		.rd_en           (rd_en),
		.rd_addr         (rd_addr),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.qdr_a_lanes     (qdr_a_lanes),
		.qdr_wps_n       (qdr_wps_n),
		.qdr_rps_n       (qdr_rps_n),
		.qdr_bws_n_lanes (qdr_bws_n_lanes),
		.qdr_d_lanes     (qdr_d_lanes),
		.rd              (u_rd_if.phaser)
	);

	// Reads in flight
	qdr_rd_tracker u_tracker (
		.clk_ctl    (clk_ctl),
		.serdes_rst (serdes_rst),
		.rd         (u_rd_if.tracker)
	);

	// Read burst assembly
	qdr_rd_capture u_capture (
		.clk_ctl        (clk_ctl),
		.serdes_rst     (serdes_rst),
		.qdr_q_lanes    (qdr_q_lanes),
		.qdr_qvld_lanes (qdr_qvld_lanes),
		.rd_valid       (rd_valid),
		.rd_data        (rd_data),
		.rd             (u_rd_if.capture)
	);

	// Sticky error levels straight from the tracker
	assign rd_err     = u_rd_if.rd_overrun;
	assign rd_timeout = u_rd_if.rd_timeout;

endmodule

// ==== src/qdr_pkg.sv ====
package qdr_pkg;

	////////////////////////////////////////////////////////////////////////////
	// RAM side geometry
	////////////////////////////////////////////////////////////////////////////

	// Bits per data beat on the QDR data buses
	localparam int RAM_WIDTH = 36;

	// Address width, shared by the read and write ports
	localparam int ADDR_BITS = 18;

	// Burst length 4, so one burst per controller cycle
	localparam int BURST_BEATS = 4;

	// One write port slot and one read port slot per cycle
	localparam int ADDR_SLOTS = 2;

	// User side word carries a whole burst
	localparam int CTRL_WIDTH = RAM_WIDTH * BURST_BEATS;

	////////////////////////////////////////////////////////////////////////////
	// Read tracking
	////////////////////////////////////////////////////////////////////////////

	// Most reads that may be outstanding at once
	localparam int RD_TRACK_DEPTH = 8;

	// Age in controller cycles at which a read counts as lost
	localparam int RD_TIMEOUT_CYCLES = 16;

	// Queue pointer and occupancy widths
	localparam int TRK_PTR_BITS = $clog2(RD_TRACK_DEPTH);
	localparam int TRK_CNT_BITS = TRK_PTR_BITS + 1;

	// Stamp wide enough to count up to the timeout without wrapping
	localparam int TRK_STAMP_BITS = $clog2(RD_TIMEOUT_CYCLES) + 1;

	// Tracker state, FAULT holds until reset
	typedef enum logic [1:0] {
		TRK_IDLE,
		TRK_BUSY,
		TRK_FAULT
	} trk_state_t;

endpackage

// ==== src/qdr_rd_capture.sv ====
`timescale 1ns/100ps

module qdr_rd_capture import qdr_pkg::*; (
	input  logic                                  clk_ctl,
	input  logic                                  serdes_rst,

	// Deserialized read data, slot 0 is the earliest phase
	input  logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_q_lanes,
	input  logic [BURST_BEATS-1:0]                qdr_qvld_lanes,

	// Assembled user word, beat k as word k
	output logic                                  rd_valid,
	output logic [CTRL_WIDTH-1:0]                 rd_data,

	qdr_rd_if.capture                             rd
);

	// Partial burst carried across cycles
	logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] hold_q;
	logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] hold_nxt;
	logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] done_word;
	logic [1:0]                            beat_cnt;
	logic [1:0]                            beat_nxt;
	logic                                  done;

	////////////////////////////////////////////////////////////////////////////
	// Beat steering
	////////////////////////////////////////////////////////////////////////////

	// Walk the slots in time order, each valid beat lands at the running count
	// At most four beats per cycle, so at most one burst closes per cycle
	always_comb begin
		hold_nxt  = hold_q;
		beat_nxt  = beat_cnt;
		done      = 1'b0;
		done_word = hold_q;
		for (int i = 0; i < BURST_BEATS; i++) begin
			if (qdr_qvld_lanes[i]) begin
				hold_nxt[beat_nxt] = qdr_q_lanes[i];
				// Fourth beat closes the word
				if (beat_nxt == 2'd3) begin
					done      = 1'b1;
					done_word = hold_nxt;
				end
				beat_nxt = beat_nxt + 2'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	// Beats after a closed word start the next one in the same cycle
	always_ff @(posedge clk_ctl) begin
		hold_q <= hold_nxt;
		if (done)
			rd_data <= done_word;
	end

	always_ff @(posedge clk_ctl) begin
		if (serdes_rst) begin
			beat_cnt <= 2'd0;
			rd_valid <= 1'b0;
		end else begin
			beat_cnt <= beat_nxt;
			rd_valid <= done;
		end
	end

	// Tracker retires the oldest read as the word goes out
	assign rd.burst_done = rd_valid;

endmodule

// ==== src/qdr_rd_if.sv ====
`timescale 1ns/100ps

// Read bookkeeping between the command phaser, read tracker and read capture
interface qdr_rd_if;

	// One cycle pulse, read select placed on the lanes
	logic rd_issue;

	// One cycle pulse, a full 4-beat read burst was assembled
	logic burst_done;

	// Sticky error levels from the tracker
	// Completion with nothing outstanding, or issue into a full queue
	logic rd_overrun;
	// Oldest read unanswered for too long
	logic rd_timeout;

	// Command side only announces reads
	modport phaser (
		output rd_issue
	);

	// Tracker sees both ends of every read
	modport tracker (
		input  rd_issue,
		input  burst_done,
		output rd_overrun,
		output rd_timeout
	);

	// Capture side reports finished bursts
	modport capture (
		output burst_done
	);

endinterface

// ==== src/qdr_rd_tracker.sv ====
`timescale 1ns/100ps

module qdr_rd_tracker import qdr_pkg::*; (
	input logic         clk_ctl,
	input logic         serdes_rst,
	qdr_rd_if.tracker   rd
);

	// Issue stamps of outstanding reads, oldest at rd_ptr
	logic [TRK_STAMP_BITS-1:0] stamp_q [RD_TRACK_DEPTH];
	logic [TRK_STAMP_BITS-1:0] cycle_cnt;
	logic [TRK_STAMP_BITS-1:0] oldest_age;
	logic [TRK_PTR_BITS-1:0]   wr_ptr;
	logic [TRK_PTR_BITS-1:0]   rd_ptr;
	logic [TRK_CNT_BITS-1:0]   count;
	logic [TRK_CNT_BITS-1:0]   count_nxt;
	trk_state_t                state;
	logic                      q_empty;
	logic                      q_full;
	logic                      do_push;
	logic                      do_pop;
	logic                      push_err;
	logic                      pop_err;
	logic                      age_err;

	assign q_empty = (count == '0);
	assign q_full  = (count == TRK_CNT_BITS'(RD_TRACK_DEPTH));

	// A pop in the same cycle frees a slot for a push into a full queue
	assign do_pop   = rd.burst_done && !q_empty;
	assign do_push  = rd.rd_issue && (!q_full || do_pop);
	assign pop_err  = rd.burst_done && q_empty;
	assign push_err = rd.rd_issue && q_full && !do_pop;

	assign count_nxt = count + TRK_CNT_BITS'(do_push) - TRK_CNT_BITS'(do_pop);

	// Modulo age of the oldest read, valid while the queue holds anything
	assign oldest_age = cycle_cnt - stamp_q[rd_ptr];
	assign age_err    = (state != TRK_IDLE) && !q_empty &&
		(oldest_age >= TRK_STAMP_BITS'(RD_TIMEOUT_CYCLES));

	always_ff @(posedge clk_ctl) begin
		if (do_push)
			stamp_q[wr_ptr] <= cycle_cnt;
	end

	always_ff @(posedge clk_ctl) begin
		if (serdes_rst) begin
			cycle_cnt     <= '0;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			state         <= TRK_IDLE;
			rd.rd_overrun <= 1'b0;
			rd.rd_timeout <= 1'b0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_nxt;

			// Error levels only ever rise
			rd.rd_overrun <= rd.rd_overrun | push_err | pop_err;
			rd.rd_timeout <= rd.rd_timeout | age_err;

			if (push_err || pop_err || age_err)
				state <= TRK_FAULT;
			else if (state != TRK_FAULT)
				state <= (count_nxt != '0) ? TRK_BUSY : TRK_IDLE;
		end
	end

endmodule

// ==== test/qdr_ctl_checker.sv ====
`timescale 1ns/100ps

module qdr_ctl_checker import qdr_pkg::*; (
	input logic                   clk_ctl,
	input logic                   serdes_rst,
	input logic                   rd_valid,
	input logic                   rd_err,
	input logic                   rd_timeout,
	input logic [BURST_BEATS-1:0] qdr_qvld_lanes,
	input logic                   qdr_wps_n,
	input logic [BURST_BEATS-1:0] qdr_bws_n_lanes
);

	// Count of failed assertions
	int fail_cnt = 0;

	////////////////////////////////////////////////////////////////////////////
	// Read side strobes
	////////////////////////////////////////////////////////////////////////////

	// A word goes out only in the cycle after returned beats
	a_valid_after_beat: assert property (@(posedge clk_ctl) disable iff (serdes_rst)
		rd_valid |-> $past(|qdr_qvld_lanes))
	else begin
		$error("rd_valid with no read beats in the cycle before");
		fail_cnt++;
	end

	// Sticky error levels
	a_err_sticky: assert property (@(posedge clk_ctl) disable iff (serdes_rst)
		rd_err |=> rd_err)
	else begin
		$error("rd_err dropped without reset");
		fail_cnt++;
	end

	a_timeout_sticky: assert property (@(posedge clk_ctl) disable iff (serdes_rst)
		rd_timeout |=> rd_timeout)
	else begin
		$error("rd_timeout dropped without reset");
		fail_cnt++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Write lanes
	////////////////////////////////////////////////////////////////////////////

	// Upper byte write slots belong to the write now on wps_n
	a_bws_upper: assert property (@(posedge clk_ctl) disable iff (serdes_rst)
		qdr_bws_n_lanes[3:2] == {2{qdr_wps_n}})
	else begin
		$error("bws slots 2 and 3 differ from qdr_wps_n");
		fail_cnt++;
	end

endmodule

bind qdr_ctl_top qdr_ctl_checker u_checker (
	.clk_ctl         (clk_ctl),
	.serdes_rst      (serdes_rst),
	.rd_valid        (rd_valid),
	.rd_err          (rd_err),
	.rd_timeout      (rd_timeout),
	.qdr_qvld_lanes  (qdr_qvld_lanes),
	.qdr_wps_n       (qdr_wps_n),
	.qdr_bws_n_lanes (qdr_bws_n_lanes)
);

// ==== test/qdr_scoreboard.sv ====
`timescale 1ns/100ps

module qdr_scoreboard import qdr_pkg::*; (
	input  logic                                  clk_ctl,
	input  logic                                  serdes_rst,
	input  logic                                  rd_en,
	input  logic [ADDR_BITS-1:0]                  rd_addr,
	input  logic                                  wr_en,
	input  logic [ADDR_BITS-1:0]                  wr_addr,
	input  logic [CTRL_WIDTH-1:0]                 wr_data,
	input  logic                                  rd_valid,
	input  logic [CTRL_WIDTH-1:0]                 rd_data,
	input  logic                                  rd_err,
	input  logic                                  rd_timeout,
	input  logic [ADDR_SLOTS-1:0][ADDR_BITS-1:0]  qdr_a_lanes,
	input  logic                                  qdr_wps_n,
	input  logic                                  qdr_rps_n,
	input  logic [BURST_BEATS-1:0]                qdr_bws_n_lanes,
	input  logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_d_lanes,
	// Read in this cycle gets no answer from the SRAM model
	input  logic                                  rd_hold,
	// Bursts with nothing outstanding are expected
	input  logic                                  stray_ok,
	output int                                    err_cnt,
	output int                                    test_cnt,
	output int                                    pending,
	output logic                                  err_s,
	output logic                                  timeout_s
);

	// User view of memory and the words still owed, oldest first
	logic [CTRL_WIDTH-1:0] ref_mem [logic [ADDR_BITS-1:0]];
	logic [CTRL_WIDTH-1:0] exp_q [$];

	// Inputs one and two cycles back
	logic                  rst_p1 = 1'b1;
	logic                  rst_p2 = 1'b1;
	logic                  rd_en_p1;
	logic                  wr_en_p1;
	logic                  wr_en_p2;
	logic [ADDR_BITS-1:0]  rd_addr_p1;
	logic [ADDR_BITS-1:0]  wr_addr_p1;
	logic [CTRL_WIDTH-1:0] data_p1;
	logic [CTRL_WIDTH-1:0] data_p2;
	int                    test_err;

	initial begin
		err_cnt   = 0;
		test_cnt  = 0;
		pending   = 0;
		test_err  = 0;
		err_s     = 1'b0;
		timeout_s = 1'b0;
	end

	// Word k of a user word sits at bit k*RAM_WIDTH
	function automatic logic [RAM_WIDTH-1:0] beat(input logic [CTRL_WIDTH-1:0] w, input int k);
		return w[k*RAM_WIDTH +: RAM_WIDTH];
	endfunction

	task automatic cmp(input string name, input logic [CTRL_WIDTH-1:0] exp,
		input logic [CTRL_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("ERR %s exp=%0h act=%0h", name, exp, act);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic note_fail(input string msg);
		$display("ERROR: %s", msg);
		err_cnt++;
		test_err++;
	endtask

	// Error levels as sampled at the last falling edge
	task automatic check_flags(input logic exp_err, input logic exp_to);
		cmp("rd_err", exp_err, err_s);
		cmp("rd_timeout", exp_to, timeout_s);
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (test_err == 0)
			$display("test %0d %s: ok", test_cnt, name);
		else
			$display("test %0d %s: %0d errors", test_cnt, name, test_err);
		test_err = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sampling on the falling edge, away from the DUT's own edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_ctl) begin
		logic                   wps_exp;
		logic                   rps_exp;
		logic [BURST_BEATS-1:0] bws_exp;
		logic [CTRL_WIDTH-1:0]  word;

		// Lanes now carry the requests of the previous cycle
		wps_exp      = rst_p1 ? 1'b1 : !wr_en_p1;
		rps_exp      = rst_p1 ? 1'b1 : !rd_en_p1;
		bws_exp[3:2] = {2{wps_exp}};
		bws_exp[1:0] = (rst_p1 || rst_p2) ? 2'b11 : {2{!wr_en_p2}};
		cmp("qdr_wps_n", wps_exp, qdr_wps_n);
		cmp("qdr_rps_n", rps_exp, qdr_rps_n);
		cmp("qdr_bws_n_lanes", bws_exp, qdr_bws_n_lanes);

		// Upper half of the new write goes out right away
		if (!wps_exp) begin
			cmp("qdr_a_lanes[0]", wr_addr_p1, qdr_a_lanes[0]);
			cmp("qdr_d_lanes[2]", beat(data_p1, 3), qdr_d_lanes[2]);
			cmp("qdr_d_lanes[3]", beat(data_p1, 2), qdr_d_lanes[3]);
		end
		// Lower half trails by one cycle
		if (!bws_exp[0]) begin
			cmp("qdr_d_lanes[0]", beat(data_p2, 1), qdr_d_lanes[0]);
			cmp("qdr_d_lanes[1]", beat(data_p2, 0), qdr_d_lanes[1]);
		end
		if (!rps_exp)
			cmp("qdr_a_lanes[1]", rd_addr_p1, qdr_a_lanes[1]);

		// Returned words must come back in issue order
		if (serdes_rst) begin
			exp_q.delete();
		end else if (rd_valid) begin
			if (exp_q.size() > 0) begin
				word = exp_q.pop_front();
				cmp("rd_data", word, rd_data);
			end else if (!stray_ok) begin
				note_fail("rd_valid pulsed with no read outstanding");
			end
		end

		if (!serdes_rst && wr_en)
			ref_mem[wr_addr] = wr_data;
		if (!serdes_rst && rd_en && !rd_hold) begin
			if (ref_mem.exists(rd_addr))
				exp_q.push_back(ref_mem[rd_addr]);
			else
				note_fail("read issued to an address that was never written");
		end

		pending   = exp_q.size();
		err_s     = rd_err;
		timeout_s = rd_timeout;

		// History shift
		rst_p2     = rst_p1;
		wr_en_p2   = wr_en_p1;
		data_p2    = data_p1;
		rst_p1     = serdes_rst;
		rd_en_p1   = rd_en;
		wr_en_p1   = wr_en;
		rd_addr_p1 = rd_addr;
		wr_addr_p1 = wr_addr;
		data_p1    = wr_data;
	end

endmodule

// ==== test/tb_qdr_ctl.sv ====
`timescale 1ns/100ps

module tb_qdr_ctl import qdr_pkg::*;;

	localparam int SRAM_LAT_PHASES = 4;
	localparam int FUT_CYCLES      = 4;
	localparam int NUM_ROWS        = 21;
	localparam int SEED            = 53954;
	localparam int DRAIN_LIMIT     = 32;
	localparam int FLAG_LIMIT      = RD_TIMEOUT_CYCLES + 8;

	localparam logic [ADDR_BITS-1:0] ADDR_A = 18'h00a5c;
	localparam logic [ADDR_BITS-1:0] ADDR_B = 18'h23f10;
	localparam logic [ADDR_BITS-1:0] ADDR_C = 18'h3ffff;

	typedef enum {OP_IDLE, OP_WR, OP_RD, OP_STRAY, OP_RESET, OP_CHECK} op_t;

	// One stimulus row
	// CHECK rows carry the expected error levels
	typedef struct {
		op_t                  op;
		logic [ADDR_BITS-1:0] addr;
		int                   off;
		logic                 hold;
		logic                 exp_err;
		logic                 exp_to;
		string                name;
	} row_t;

	row_t                  rows [NUM_ROWS];
	logic [CTRL_WIDTH-1:0] data_tab [NUM_ROWS];
	int                    n_rows;

	logic                                  clk_ctl = 1'b0;
	logic                                  serdes_rst;
	logic                                  rd_en;
	logic [ADDR_BITS-1:0]                  rd_addr;
	logic                                  wr_en;
	logic [ADDR_BITS-1:0]                  wr_addr;
	logic [CTRL_WIDTH-1:0]                 wr_data;
	logic                                  rd_valid;
	logic [CTRL_WIDTH-1:0]                 rd_data;
	logic                                  rd_err;
	logic                                  rd_timeout;
	logic [ADDR_SLOTS-1:0][ADDR_BITS-1:0]  qdr_a_lanes;
	logic                                  qdr_wps_n;
	logic                                  qdr_rps_n;
	logic [BURST_BEATS-1:0]                qdr_bws_n_lanes;
	logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_d_lanes;
	logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] qdr_q_lanes;
	logic [BURST_BEATS-1:0]                qdr_qvld_lanes;

	// Row side info for the SRAM model and the scoreboard
	logic rd_hold;
	logic stray_row;
	logic stray_ok;
	int   row_off;

	int   sb_err;
	int   sb_tests;
	int   sb_pending;
	logic sb_err_s;
	logic sb_timeout_s;

	always #5 clk_ctl = ~clk_ctl;

	qdr_ctl_top u_qdr_ctl_top (
		.clk_ctl         (clk_ctl),
		.serdes_rst      (serdes_rst),
		.rd_en           (rd_en),
		.rd_addr         (rd_addr),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.rd_err          (rd_err),
		.rd_timeout      (rd_timeout),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.qdr_a_lanes     (qdr_a_lanes),
		.qdr_wps_n       (qdr_wps_n),
		.qdr_rps_n       (qdr_rps_n),
		.qdr_bws_n_lanes (qdr_bws_n_lanes),
		.qdr_d_lanes     (qdr_d_lanes),
		.qdr_q_lanes     (qdr_q_lanes),
		.qdr_qvld_lanes  (qdr_qvld_lanes)
	);

	qdr_scoreboard u_sb (
		.clk_ctl         (clk_ctl),
		.serdes_rst      (serdes_rst),
		.rd_en           (rd_en),
		.rd_addr         (rd_addr),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.rd_err          (rd_err),
		.rd_timeout      (rd_timeout),
		.qdr_a_lanes     (qdr_a_lanes),
		.qdr_wps_n       (qdr_wps_n),
		.qdr_rps_n       (qdr_rps_n),
		.qdr_bws_n_lanes (qdr_bws_n_lanes),
		.qdr_d_lanes     (qdr_d_lanes),
		.rd_hold         (rd_hold),
		.stray_ok        (stray_ok),
		.err_cnt         (sb_err),
		.test_cnt        (sb_tests),
		.pending         (sb_pending),
		.err_s           (sb_err_s),
		.timeout_s       (sb_timeout_s)
	);

	////////////////////////////////////////////////////////////////////////////
	// Behavioral SRAM on the lane side
	////////////////////////////////////////////////////////////////////////////

	logic [CTRL_WIDTH-1:0]                 sram [logic [ADDR_BITS-1:0]];
	// Beats owed in future cycles
	// Entry 0 goes out on the next rising edge
	logic [BURST_BEATS-1:0][RAM_WIDTH-1:0] fut_q [FUT_CYCLES];
	logic [BURST_BEATS-1:0]                fut_v [FUT_CYCLES];
	logic [ADDR_BITS-1:0]                  wr_pend_addr;
	logic [2*RAM_WIDTH-1:0]                wr_hi;
	logic                                  wr_pend = 1'b0;
	logic                                  hold_d = 1'b0;
	int                                    off_d = 0;

	always @(negedge clk_ctl) begin
		logic [CTRL_WIDTH-1:0] word;
		int                    ph;

		// Lower half of a write lands one cycle after the upper half
		if (wr_pend)
			sram[wr_pend_addr] = {wr_hi, qdr_d_lanes[0], qdr_d_lanes[1]};
		wr_pend      = !qdr_wps_n;
		wr_pend_addr = qdr_a_lanes[0];
		wr_hi        = {qdr_d_lanes[2], qdr_d_lanes[3]};

		// Read answered at a fixed latency plus the row's phase offset
		if (!qdr_rps_n && !hold_d) begin
			word = sram.exists(qdr_a_lanes[1]) ? sram[qdr_a_lanes[1]] : '0;
			for (int j = 0; j < BURST_BEATS; j++) begin
				ph = SRAM_LAT_PHASES + off_d + j;
				fut_q[ph / BURST_BEATS][ph % BURST_BEATS] = word[j*RAM_WIDTH +: RAM_WIDTH];
				fut_v[ph / BURST_BEATS][ph % BURST_BEATS] = 1'b1;
			end
		end

		// A full burst that nobody asked for
		if (stray_row) begin
			for (int j = 0; j < BURST_BEATS; j++)
				fut_q[0][j] = wr_data[j*RAM_WIDTH +: RAM_WIDTH];
			fut_v[0] = '1;
		end

		off_d  = row_off;
		hold_d = rd_hold;
	end

	always @(posedge clk_ctl) begin
		qdr_q_lanes    <= fut_q[0];
		qdr_qvld_lanes <= fut_v[0];
		for (int c = 0; c < FUT_CYCLES - 1; c++) begin
			fut_q[c] = fut_q[c+1];
			fut_v[c] = fut_v[c+1];
		end
		fut_q[FUT_CYCLES-1] = '0;
		fut_v[FUT_CYCLES-1] = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_row(input op_t op, input logic [ADDR_BITS-1:0] addr, input int off,
		input logic hold, input logic exp_err, input logic exp_to, input string name);
		rows[n_rows].op      = op;
		rows[n_rows].addr    = addr;
		rows[n_rows].off     = off;
		rows[n_rows].hold    = hold;
		rows[n_rows].exp_err = exp_err;
		rows[n_rows].exp_to  = exp_to;
		rows[n_rows].name    = name;
		n_rows++;
	endtask

	task automatic load_table();
		n_rows = 0;
		add_row(OP_IDLE,  '0,     0, 0, 0, 0, "");
		add_row(OP_IDLE,  '0,     0, 0, 0, 0, "");
		add_row(OP_CHECK, '0,     0, 0, 0, 0, "idle after reset");
		// Single write then two back to back
		add_row(OP_WR,    ADDR_A, 0, 0, 0, 0, "");
		add_row(OP_IDLE,  '0,     0, 0, 0, 0, "");
		add_row(OP_IDLE,  '0,     0, 0, 0, 0, "");
		add_row(OP_WR,    ADDR_B, 0, 0, 0, 0, "");
		add_row(OP_WR,    ADDR_C, 0, 0, 0, 0, "");
		add_row(OP_IDLE,  '0,     0, 0, 0, 0, "");
		add_row(OP_CHECK, '0,     0, 0, 0, 0, "write lanes");
		add_row(OP_RD,    ADDR_A, 0, 0, 0, 0, "");
		add_row(OP_CHECK, '0,     0, 0, 0, 0, "read offset 0");
		// Every burst straddles two controller cycles
		add_row(OP_RD,    ADDR_B, 2, 0, 0, 0, "");
		add_row(OP_RD,    ADDR_C, 2, 0, 0, 0, "");
		add_row(OP_RD,    ADDR_A, 2, 0, 0, 0, "");
		add_row(OP_CHECK, '0,     0, 0, 0, 0, "back to back reads offset 2");
		add_row(OP_STRAY, '0,     0, 0, 0, 0, "");
		add_row(OP_CHECK, '0,     0, 0, 1, 0, "burst with no read outstanding");
		add_row(OP_RESET, '0,     0, 0, 0, 0, "");
		add_row(OP_RD,    ADDR_B, 0, 1, 0, 0, "");
		add_row(OP_CHECK, '0,     0, 0, 0, 1, "withheld read");
	endtask

	task automatic drive_idle();
		rd_en     <= 1'b0;
		wr_en     <= 1'b0;
		rd_hold   <= 1'b0;
		stray_row <= 1'b0;
		row_off   <= 0;
	endtask

	task automatic apply_reset();
		@(posedge clk_ctl);
		serdes_rst <= 1'b1;
		stray_ok   <= 1'b0;
		drive_idle();
		repeat (5) @(posedge clk_ctl);
		serdes_rst <= 1'b0;
	endtask

	// Outstanding reads must all come back
	task automatic wait_drain();
		int n;
		n = 0;
		while (sb_pending != 0 && n < DRAIN_LIMIT) begin
			@(posedge clk_ctl);
			n++;
		end
		if (sb_pending != 0)
			u_sb.note_fail($sformatf("%0d reads got no rd_valid in %0d cycles",
				sb_pending, DRAIN_LIMIT));
	endtask

	// Error levels may rise some cycles after the cause
	task automatic wait_flags(input logic exp_err, input logic exp_to);
		int n;
		n = 0;
		while ((sb_err_s !== exp_err || sb_timeout_s !== exp_to) && n < FLAG_LIMIT) begin
			@(posedge clk_ctl);
			n++;
		end
	endtask

	initial begin
		int           seed;
		int           total;
		logic [159:0] rnd;
		row_t         r;

		seed       = SEED;
		serdes_rst = 1'b1;
		rd_en      = 1'b0;
		rd_addr    = '0;
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		rd_hold    = 1'b0;
		stray_row  = 1'b0;
		stray_ok   = 1'b0;
		row_off    = 0;
		qdr_q_lanes    = '0;
		qdr_qvld_lanes = '0;
		for (int c = 0; c < FUT_CYCLES; c++) begin
			fut_q[c] = '0;
			fut_v[c] = '0;
		end

		load_table();
		for (int i = 0; i < NUM_ROWS; i++) begin
			rnd = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
			data_tab[i] = rnd[CTRL_WIDTH-1:0];
		end

		repeat (5) @(posedge clk_ctl);
		serdes_rst <= 1'b0;

		for (int i = 0; i < NUM_ROWS; i++) begin
			r = rows[i];
			case (r.op)
				OP_RESET: apply_reset();
				OP_CHECK: begin
					@(posedge clk_ctl);
					drive_idle();
					wait_drain();
					wait_flags(r.exp_err, r.exp_to);
					u_sb.check_flags(r.exp_err, r.exp_to);
					u_sb.end_test(r.name);
				end
				default: begin
					@(posedge clk_ctl);
					rd_en     <= (r.op == OP_RD);
					wr_en     <= (r.op == OP_WR);
					rd_addr   <= r.addr;
					wr_addr   <= r.addr;
					wr_data   <= data_tab[i];
					rd_hold   <= r.hold;
					row_off   <= r.off;
					stray_row <= (r.op == OP_STRAY);
					if (r.op == OP_STRAY)
						stray_ok <= 1'b1;
				end
			endcase
		end

		@(posedge clk_ctl);
		total = sb_err + u_qdr_ctl_top.u_checker.fail_cnt;
		$display("%0d tests, %0d errors", sb_tests, total);
		if (total == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
